//--- filelist.f
rtl/spec_pkg.sv
rtl/magnitude.sv
rtl/spectrum_ram.sv
rtl/spec_arbiter.sv
rtl/mel_bands.sv
rtl/spectrum_top.sv
verif/spectrum_tb.sv

//--- Bender.yml
package:
  name: spectrum_frontend

sources:
  - files:
      - rtl/spec_pkg.sv
      - rtl/magnitude.sv
      - rtl/spectrum_ram.sv
      - rtl/spec_arbiter.sv
      - rtl/mel_bands.sv
      - rtl/spectrum_top.sv
  - target: simulation
    files:
      - verif/spectrum_tb.sv

//--- verif/spectrum_tb.sv
// directed tests for N_BINS=32, N_BANDS=4; lfsr seed truncated to 16 bits; bounded waits only
module spectrum_tb;

    import spec_pkg::*;

    localparam int N_BINS    = 32;
    localparam int N_BANDS   = 4;
    localparam int ADDR_W    = $clog2(N_BINS);
    localparam int BIDX_W    = $clog2(N_BANDS);
    localparam int BPB       = N_BINS / N_BANDS;   // bins per band
    localparam int LFSR_SEED = 91737;
    localparam int HOST_TMO  = 200;                // cycles per host read
    localparam int MEL_TMO   = 3000;               // cycles until mel_done

    logic              clk, rst;
    logic              bin_valid, bin_last;
    logic [ADDR_W-1:0] bin_idx;
    fft_sample_t       real_part, imag_part;
    logic              host_rd_req, host_rd_valid;
    logic [ADDR_W-1:0] host_rd_addr;
    mag_t              host_rd_data;
    logic              band_valid, mel_done;
    logic [BIDX_W-1:0] band_idx;
    band_t             band_energy;

    logic [15:0]       lfsr_state;
    int                err_cnt, chk_cnt;
    logic              sweep_over;                 // contention test stop flag
    fft_sample_t       re_arr [N_BINS];
    fft_sample_t       im_arr [N_BINS];
    mag_t              exp_mag [N_BINS];           // model of the stored spectrum
    band_t             band_e_q [$];               // captured band outputs
    logic [BIDX_W-1:0] band_i_q [$];

    spectrum_top #(.N_BINS(N_BINS), .N_BANDS(N_BANDS)) dut_i (.*);

    always #4 clk = ~clk;

    // band outputs sampled mid-cycle, away from the edge
    always @(negedge clk) begin
        if (band_valid) begin
            band_e_q.push_back(band_energy);
            band_i_q.push_back(band_idx);
        end
    end

    // --------------------------------------------------
    // random source and reference model
    // --------------------------------------------------
    function automatic logic next_bit();
        logic fb;
        fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};       // x^16+x^14+x^13+x^11+1
        return fb;
    endfunction

    function automatic logic [15:0] rand_bits(int n);
        logic [15:0] v;
        v = '0;
        for (int k = 0; k < n; k++) v = {v[14:0], next_bit()};   // one step per bit
        return v;
    endfunction

    function automatic mag_t mag_model(fft_sample_t re, fft_sample_t im);
        longint a, b, s, r, t;
        a = (re < 0) ? -longint'(re) : longint'(re);
        b = (im < 0) ? -longint'(im) : longint'(im);
        s = a * a + b * b;
        r = 0;
        for (int k = MAG_WIDTH - 1; k >= 0; k--) begin
            t = r | (longint'(1) << k);            // try setting this bit
            if (t * t <= s) r = t;
        end
        return mag_t'(r);
    endfunction

    function automatic band_t band_model(int b);
        band_t sum;
        sum = '0;
        for (int i = b * BPB; i < (b + 1) * BPB; i++) sum += band_t'(exp_mag[i]);
        return sum;
    endfunction

    // --------------------------------------------------
    // compare tasks
    // --------------------------------------------------
    task automatic check_mag(input string name, input mag_t exp, input mag_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_band(input string name, input band_t exp, input band_t act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_band_idx(input string name, input logic [BIDX_W-1:0] exp,
                                  input logic [BIDX_W-1:0] act);
        chk_cnt++;
        if (act !== exp) begin
            err_cnt++;
            $display("MISMATCH %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    // --------------------------------------------------
    // drivers and waits
    // --------------------------------------------------
    task automatic apply_reset();
        @(posedge clk); #1;
        rst       = 1'b1;
        bin_valid = 1'b0;
        bin_last  = 1'b0;
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;
    endtask

    task automatic drive_bin(input int idx, input fft_sample_t re, input fft_sample_t im,
                             input logic last);
        @(posedge clk); #1;
        bin_valid = 1'b1;
        bin_idx   = ADDR_W'(idx);
        bin_last  = last;
        real_part = re;
        imag_part = im;
    endtask

    task automatic stream_frame();
        for (int i = 0; i < N_BINS; i++) drive_bin(i, re_arr[i], im_arr[i], i == N_BINS - 1);
        @(posedge clk); #1;
        bin_valid = 1'b0;                          // back to idle after the last bin
        bin_last  = 1'b0;
    endtask

    task automatic fill_random_frame();
        for (int i = 0; i < N_BINS; i++) begin
            re_arr[i]  = fft_sample_t'(rand_bits(FFT_DATA_WIDTH));
            im_arr[i]  = fft_sample_t'(rand_bits(FFT_DATA_WIDTH));
            exp_mag[i] = mag_model(re_arr[i], im_arr[i]);
        end
    endtask

    task automatic wait_mel_done(input string name);
        logic seen;
        seen = 1'b0;
        for (int n = 0; n < MEL_TMO && !seen; n++) begin
            @(negedge clk);
            seen = mel_done;
        end
        if (!seen) begin
            err_cnt++;
            $display("ERROR %s: mel_done never came within %0d cycles", name, MEL_TMO);
        end
    endtask

    // request held until the valid strobe, then dropped
    task automatic host_read(input string name, input logic [ADDR_W-1:0] addr,
                             output mag_t data, output logic ok);
        ok   = 1'b0;
        data = '0;
        @(posedge clk); #1;
        host_rd_req  = 1'b1;
        host_rd_addr = addr;
        for (int n = 0; n < HOST_TMO && !ok; n++) begin
            @(negedge clk);
            if (host_rd_valid) begin
                data = host_rd_data;
                ok   = 1'b1;
            end
        end
        @(posedge clk); #1;
        host_rd_req = 1'b0;
        if (!ok) begin
            err_cnt++;
            $display("ERROR %s: host read of bin %0d got no valid in %0d cycles",
                     name, addr, HOST_TMO);
        end
    endtask

    task automatic check_bands(input string name);
        if (band_e_q.size() != N_BANDS) begin
            err_cnt++;
            $display("ERROR %s: saw %0d bands instead of %0d", name, band_e_q.size(), N_BANDS);
        end else begin
            for (int b = 0; b < N_BANDS; b++) begin
                check_band_idx($sformatf("%s band %0d index", name, b), BIDX_W'(b),
                               band_i_q[b]);
                check_band($sformatf("%s band %0d", name, b), band_model(b), band_e_q[b]);
            end
        end
    endtask

    task automatic readback_frame(input string name);
        mag_t d;
        logic ok;
        for (int i = 0; i < N_BINS; i++) begin
            host_read(name, ADDR_W'(i), d, ok);
            if (ok) check_mag($sformatf("%s bin %0d", name, i), exp_mag[i], d);
        end
    endtask

    // --------------------------------------------------
    // directed tests
    // --------------------------------------------------
    task automatic corner_bins();
        int          cre [6] = '{0, 1000, 0, -300, -32768, 3};
        int          cim [6] = '{0, 0, -1234, -400, -32768, 4};
        mag_t        d;
        logic        ok;
        for (int i = 0; i < 6; i++) begin
            band_e_q.delete();
            band_i_q.delete();
            exp_mag[i] = mag_model(fft_sample_t'(cre[i]), fft_sample_t'(cim[i]));
            drive_bin(i, fft_sample_t'(cre[i]), fft_sample_t'(cim[i]), 1'b1);
            @(posedge clk); #1 bin_valid = 1'b0;
            wait_mel_done("corner");               // last flag marks the write as done
            host_read("corner", ADDR_W'(i), d, ok);
            if (ok) check_mag($sformatf("corner bin %0d", i), exp_mag[i], d);
        end
    endtask

    task automatic streamed_frame();
        band_e_q.delete();
        band_i_q.delete();
        fill_random_frame();
        stream_frame();                            // up to 19 bins in flight
        wait_mel_done("streamed");
        readback_frame("streamed");
    endtask

    task automatic band_energies();
        check_bands("bands");                      // bands kept from the streamed frame
    endtask

    // new frame while host reads race the writes and the sweep;
    // a read issued before the last write may still see the previous frame
    task automatic host_contention();
        mag_t              d;
        logic              ok;
        logic              late;                   // read issued after every write landed
        logic              writes_done;
        logic [ADDR_W-1:0] a;
        mag_t              old_mag [N_BINS];       // previous frame still in memory
        band_e_q.delete();
        band_i_q.delete();
        sweep_over  = 1'b0;
        writes_done = 1'b0;
        old_mag     = exp_mag;
        fill_random_frame();
        fork
            begin
                stream_frame();
                repeat (MAG_LATENCY) @(posedge clk);   // last bin reaches the memory
                writes_done = 1'b1;
            end
            begin
                wait_mel_done("contention");
                sweep_over = 1'b1;
            end
            begin
                while (!sweep_over) begin
                    a    = ADDR_W'(rand_bits(ADDR_W));
                    late = writes_done;
                    host_read("contention", a, d, ok);
                    // old value only acceptable before the frame is fully written
                    if (ok && (late || d !== old_mag[a])) begin
                        check_mag($sformatf("contention bin %0d", a), exp_mag[a], d);
                    end
                end
            end
        join
        check_bands("contention");
    endtask

    task automatic back_to_back_frames();
        band_e_q.delete();
        band_i_q.delete();
        fill_random_frame();                       // new data over the old frame
        stream_frame();
        wait_mel_done("second frame");
        check_bands("second frame");
        readback_frame("second frame");
    endtask

    task automatic reset_mid_frame();
        fill_random_frame();
        stream_frame();
        apply_reset();                             // hits while bins are still in the pipe
        band_e_q.delete();
        band_i_q.delete();
        for (int n = 0; n < 60; n++) begin
            @(negedge clk);
            if (band_valid || mel_done || host_rd_valid) begin
                err_cnt++;
                $display("ERROR reset: outputs active %0d cycles after reset", n);
            end
        end
        back_to_back_frames();                     // fresh frame after reset
    endtask

    // --------------------------------------------------
    // main sequence
    // --------------------------------------------------
    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        bin_valid    = 1'b0;
        bin_last     = 1'b0;
        bin_idx      = '0;
        real_part    = '0;
        imag_part    = '0;
        host_rd_req  = 1'b0;
        host_rd_addr = '0;
        err_cnt      = 0;
        chk_cnt      = 0;
        sweep_over   = 1'b0;
        lfsr_state   = 16'(LFSR_SEED);
        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        corner_bins();
        streamed_frame();
        band_energies();
        host_contention();
        back_to_back_frames();
        reset_mid_frame();

        $display("checks: %0d  errors: %0d", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- rtl/spectrum_top.sv
// start a frame only after the previous mel_done; N_BINS must be a multiple of N_BANDS
module spectrum_top #(
    parameter int N_BINS  = 32,
    parameter int N_BANDS = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            bin_valid,
    input  logic                                            bin_last,
    input  logic [$clog2(N_BINS)-1:0]                       bin_idx,
    input  spec_pkg::fft_sample_t                           real_part,
    input  spec_pkg::fft_sample_t                           imag_part,
    input  logic                                            host_rd_req,   // hold until valid
    input  logic [$clog2(N_BINS)-1:0]                       host_rd_addr,
    output spec_pkg::mag_t                                  host_rd_data,
    output logic                                            host_rd_valid,
    output logic                                            band_valid,
    output logic [((N_BANDS > 1) ? $clog2(N_BANDS) : 1)-1:0] band_idx,
    output spec_pkg::band_t                                 band_energy,
    output logic                                            mel_done
);

    import spec_pkg::*;

    localparam int ADDR_W = $clog2(N_BINS);

    // --------------------------------------------------
    // internal nets
    // --------------------------------------------------
    logic              wr_en, frame_written;
    logic [ADDR_W-1:0] wr_addr;
    mag_t              wr_data;
    logic              mel_rd_req, mel_rd_grant, mel_rd_valid;
    logic [ADDR_W-1:0] mel_rd_addr;
    mag_t              rd_data;         // shared return data
    logic              ram_en, ram_we;
    logic [ADDR_W-1:0] ram_addr;
    mag_t              ram_wdata, ram_rdata;

    assign host_rd_data = rd_data;

    // --------------------------------------------------
    // instances
    // --------------------------------------------------
    magnitude #(.N_BINS(N_BINS)) magnitude_i (
        .clk, .rst,
        .bin_valid, .bin_idx, .bin_last, .real_part, .imag_part,
        .wr_en, .wr_addr, .wr_data, .frame_written
    );

    spec_arbiter #(.N_BINS(N_BINS)) spec_arbiter_i (
        .clk, .rst,
        .wr_en, .wr_addr, .wr_data,
        .mel_rd_req, .mel_rd_addr, .mel_rd_grant, .mel_rd_valid,
        .host_rd_req, .host_rd_addr, .host_rd_valid,
        .rd_data,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    spectrum_ram #(.N_BINS(N_BINS)) spectrum_ram_i (
        .clk,
        .ram_en, .ram_we, .ram_addr, .ram_wdata, .ram_rdata
    );

    mel_bands #(.N_BINS(N_BINS), .N_BANDS(N_BANDS)) mel_bands_i (
        .clk, .rst,
        .frame_written,
        .mel_rd_req, .mel_rd_addr, .mel_rd_grant, .mel_rd_valid,
        .rd_data,
        .band_valid, .band_idx, .band_energy, .mel_done
    );

endmodule

//--- rtl/mel_bands.sv
// rectangular bands of N_BINS/N_BANDS bins; frame_written while busy is dropped
module mel_bands #(
    parameter int N_BINS  = 32,
    parameter int N_BANDS = 4
) (
    input  logic                                            clk,
    input  logic                                            rst,
    input  logic                                            frame_written,
    output logic                                            mel_rd_req,
    output logic [$clog2(N_BINS)-1:0]                       mel_rd_addr,
    input  logic                                            mel_rd_grant,
    input  logic                                            mel_rd_valid,
    input  spec_pkg::mag_t                                  rd_data,
    output logic                                            band_valid,
    output logic [((N_BANDS > 1) ? $clog2(N_BANDS) : 1)-1:0] band_idx,
    output spec_pkg::band_t                                 band_energy,
    output logic                                            mel_done
);

    import spec_pkg::*;

    localparam int ADDR_W        = $clog2(N_BINS);
    localparam int BAND_IDX_W    = (N_BANDS > 1) ? $clog2(N_BANDS) : 1;
    localparam int BINS_PER_BAND = N_BINS / N_BANDS;
    localparam int POS_W         = (BINS_PER_BAND > 1) ? $clog2(BINS_PER_BAND) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_REQ,     // request held until granted
        S_WAIT,    // one read outstanding
        S_EMIT     // band sum on the outputs
    } state_t;

    state_t                state_q;
    logic [ADDR_W-1:0]     bin_q;      // next bin to read
    logic [POS_W-1:0]      pos_q;      // position inside the current band
    logic [BAND_IDX_W-1:0] band_q;
    band_t                 acc_q;
    logic                  done_q;
    logic                  band_end;   // returning bin closes the band
    logic                  last_band;

    assign band_end  = (pos_q == POS_W'(BINS_PER_BAND - 1));
    assign last_band = (band_q == BAND_IDX_W'(N_BANDS - 1));

    // --------------------------------------------------
    // sweep FSM
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
            bin_q   <= '0;
            pos_q   <= '0;
            band_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                S_IDLE: begin
                    if (frame_written) begin
                        bin_q   <= '0;
                        pos_q   <= '0;
                        band_q  <= '0;
                        state_q <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (mel_rd_grant) state_q <= S_WAIT;
                end
                S_WAIT: begin
                    if (mel_rd_valid) begin
                        bin_q <= bin_q + 1'b1;              // wraps after the final bin
                        if (band_end) begin
                            pos_q   <= '0;
                            state_q <= S_EMIT;
                        end else begin
                            pos_q   <= pos_q + 1'b1;
                            state_q <= S_REQ;
                        end
                    end
                end
                S_EMIT: begin
                    band_q <= band_q + 1'b1;
                    if (last_band) begin
                        done_q  <= 1'b1;                    // one cycle after last band_valid
                        state_q <= S_IDLE;
                    end else begin
                        state_q <= S_REQ;
                    end
                end
                default: state_q <= S_IDLE;
            endcase
        end
    end

    // --------------------------------------------------
    // accumulator
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (state_q == S_IDLE || state_q == S_EMIT) begin
            acc_q <= '0;                                  // fresh sum per band
        end else if (state_q == S_WAIT && mel_rd_valid) begin
            acc_q <= acc_q + BAND_WIDTH'(rd_data);
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign mel_rd_req  = (state_q == S_REQ);
    assign mel_rd_addr = bin_q;
    assign band_valid  = (state_q == S_EMIT);
    assign band_idx    = band_q;
    assign band_energy = acc_q;
    assign mel_done    = done_q;

endmodule

//--- rtl/spec_arbiter.sv
// fixed priority writer > mel > host; writer is never stalled, reads return after one cycle
module spec_arbiter #(
    parameter int N_BINS = 32
) (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      wr_en,
    input  logic [$clog2(N_BINS)-1:0] wr_addr,
    input  spec_pkg::mag_t            wr_data,
    input  logic                      mel_rd_req,
    input  logic [$clog2(N_BINS)-1:0] mel_rd_addr,
    output logic                      mel_rd_grant,
    output logic                      mel_rd_valid,
    input  logic                      host_rd_req,
    input  logic [$clog2(N_BINS)-1:0] host_rd_addr,
    output logic                      host_rd_valid,
    output spec_pkg::mag_t            rd_data,
    output logic                      ram_en,
    output logic                      ram_we,
    output logic [$clog2(N_BINS)-1:0] ram_addr,
    output spec_pkg::mag_t            ram_wdata,
    input  spec_pkg::mag_t            ram_rdata
);

    logic mel_sel, host_sel;     // read grants this cycle
    logic mel_own, host_own;     // owner of the read in flight

    // --------------------------------------------------
    // selection, same cycle
    // --------------------------------------------------
    // host request still held in its valid cycle, so masked by host_own
    assign mel_sel  = !wr_en && mel_rd_req;
    assign host_sel = !wr_en && !mel_rd_req && host_rd_req && !host_own;

    assign ram_en    = wr_en | mel_sel | host_sel;
    assign ram_we    = wr_en;
    assign ram_wdata = wr_data;

    always_comb begin
        if (wr_en) begin
            ram_addr = wr_addr;
        end else if (mel_rd_req) begin
            ram_addr = mel_rd_addr;
        end else begin
            ram_addr = host_rd_addr;      // don't care when idle
        end
    end

    assign mel_rd_grant = mel_sel;

    // --------------------------------------------------
    // read return routing
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            mel_own  <= 1'b0;
            host_own <= 1'b0;
        end else begin
            mel_own  <= mel_sel;
            host_own <= host_sel;
        end
    end

    assign mel_rd_valid  = mel_own;
    assign host_rd_valid = host_own;
    assign rd_data       = ram_rdata;     // shared, qualified by the valids

endmodule

//--- rtl/spectrum_ram.sv
// single-port bin store, read data registered one cycle; contents undefined after reset
module spectrum_ram #(
    parameter int N_BINS = 32
) (
    input  logic                      clk,
    input  logic                      ram_en,
    input  logic                      ram_we,
    input  logic [$clog2(N_BINS)-1:0] ram_addr,
    input  spec_pkg::mag_t            ram_wdata,
    output spec_pkg::mag_t            ram_rdata
);

    import spec_pkg::*;

    mag_t mem [0:N_BINS-1];   // one magnitude per bin

    // --------------------------------------------------
    // write or registered read, never both
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (ram_en) begin
            if (ram_we) begin
                mem[ram_addr] <= ram_wdata;
            end else begin
                ram_rdata <= mem[ram_addr];   // holds until the next read
            end
        end
    end

endmodule

//--- rtl/magnitude.sv
// fixed latency MAG_LATENCY, one bin per cycle accepted, no back-pressure; exact floor sqrt
module magnitude #(
    parameter int N_BINS = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          bin_valid,   // one-cycle strobe
    input  logic [$clog2(N_BINS)-1:0]     bin_idx,
    input  logic                          bin_last,    // last bin of the frame
    input  spec_pkg::fft_sample_t         real_part,
    input  spec_pkg::fft_sample_t         imag_part,
    output logic                          wr_en,
    output logic [$clog2(N_BINS)-1:0]     wr_addr,
    output spec_pkg::mag_t                wr_data,
    output logic                          frame_written
);

    import spec_pkg::*;

    localparam int ADDR_W   = $clog2(N_BINS);
    localparam int N_STAGES = MAG_LATENCY - 2;    // sqrt stages, one per result bit
    localparam int REM_W    = MAG_WIDTH + 2;      // partial remainder never exceeds 2*root
    localparam int RAD_W    = SUM_WIDTH + 1;      // radicand padded to an even width

    // --------------------------------------------------
    // stage 1: absolute value and square
    // --------------------------------------------------
    logic [FFT_DATA_WIDTH:0] re_ext, im_ext;      // sign extended to 17 bits
    logic [FFT_DATA_WIDTH:0] abs_re, abs_im;      // 17 bits so -32768 stays exact
    logic [SUM_WIDTH-1:0]    sq_re, sq_im;
    logic                    s1_vld;
    logic [ADDR_W-1:0]       s1_idx;
    logic                    s1_last;

    assign re_ext = {real_part[FFT_DATA_WIDTH-1], real_part};
    assign im_ext = {imag_part[FFT_DATA_WIDTH-1], imag_part};
    assign abs_re = real_part[FFT_DATA_WIDTH-1] ? (~re_ext + 1'b1) : re_ext;
    assign abs_im = imag_part[FFT_DATA_WIDTH-1] ? (~im_ext + 1'b1) : im_ext;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else begin
            s1_vld <= bin_valid;
        end
        sq_re   <= SUM_WIDTH'(abs_re) * SUM_WIDTH'(abs_re);
        sq_im   <= SUM_WIDTH'(abs_im) * SUM_WIDTH'(abs_im);
        s1_idx  <= bin_idx;
        s1_last <= bin_last;
    end

    // --------------------------------------------------
    // stage 2: sum, seeds index 0 of the sqrt pipe
    // --------------------------------------------------
    logic                 vld_q  [0:N_STAGES];
    logic [ADDR_W-1:0]    idx_q  [0:N_STAGES];
    logic                 last_q [0:N_STAGES];
    logic [MAG_WIDTH-1:0] root_q [0:N_STAGES];
    logic [REM_W-1:0]     rem_q  [0:N_STAGES-1];
    logic [RAD_W-1:0]     rad_q  [0:N_STAGES-1]; // unconsumed radicand bits at the top

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_q[0] <= 1'b0;
        end else begin
            vld_q[0] <= s1_vld;
        end
        idx_q[0]  <= s1_idx;
        last_q[0] <= s1_last;
        rad_q[0]  <= {1'b0, sq_re + sq_im};   // max 2^31, no overflow
        rem_q[0]  <= '0;
        root_q[0] <= '0;
    end

    // --------------------------------------------------
    // restoring sqrt, msb first, one bit per stage
    // --------------------------------------------------
    for (genvar k = 1; k <= N_STAGES; k++) begin : g_sqrt
        logic [REM_W+1:0] cur;      // remainder with next two radicand bits
        logic [REM_W+1:0] trial;    // 4*root + 1
        logic [REM_W+1:0] diff;
        logic             take;     // result bit for this stage

        assign cur   = {rem_q[k-1], rad_q[k-1][RAD_W-1 -: 2]};
        assign trial = {{(REM_W - MAG_WIDTH){1'b0}}, root_q[k-1], 2'b01};
        assign take  = (cur >= trial);
        assign diff  = cur - trial;

        always_ff @(posedge clk) begin
            if (rst) begin
                vld_q[k] <= 1'b0;
            end else begin
                vld_q[k] <= vld_q[k-1];
            end
            idx_q[k]  <= idx_q[k-1];     // index and last ride with the data
            last_q[k] <= last_q[k-1];
            root_q[k] <= {root_q[k-1][MAG_WIDTH-2:0], take};
        end

        // final stage keeps only the root
        if (k < N_STAGES) begin : g_carry
            always_ff @(posedge clk) begin
                rem_q[k] <= take ? diff[REM_W-1:0] : cur[REM_W-1:0];
                rad_q[k] <= rad_q[k-1] << 2;
            end
        end
    end

    // --------------------------------------------------
    // write port toward the arbiter
    // --------------------------------------------------
    assign wr_en         = vld_q[N_STAGES];
    assign wr_addr       = idx_q[N_STAGES];
    assign wr_data       = root_q[N_STAGES];
    assign frame_written = vld_q[N_STAGES] & last_q[N_STAGES];   // with the last bin's write

endmodule

//--- rtl/spec_pkg.sv
// shared widths and types; N_BINS and N_BANDS are module parameters, not set here
package spec_pkg;

    // --------------------------------------------------
    // input side
    // --------------------------------------------------
    localparam int FFT_DATA_WIDTH = 16;           // one fft component

    typedef logic signed [FFT_DATA_WIDTH-1:0] fft_sample_t;

    // --------------------------------------------------
    // magnitude path
    // --------------------------------------------------
    // worst case re = im = -32768 gives a sum of 2^31,
    // whose floor square root is 46340
    localparam int SUM_WIDTH = 2 * FFT_DATA_WIDTH + 1;  // re^2 + im^2
    localparam int MAG_WIDTH = 17;                     // one result bit per sqrt stage

    typedef logic [MAG_WIDTH-1:0] mag_t;

    // 2 cycles abs/square and sum, then one cycle per root bit
    localparam int MAG_LATENCY = 2 + MAG_WIDTH;        // bin_valid to wr_en

    // --------------------------------------------------
    // band path
    // --------------------------------------------------
    localparam int BAND_WIDTH = 24;               // room for 128 bins per band

    typedef logic [BAND_WIDTH-1:0] band_t;

endpackage
